// ==== src/hbram_axi_bridge.sv ====
// AXI to HyperRAM controller bridge top: command FIFO, sequencer, write and read paths
`timescale 1ns/1ns

module hbram_axi_bridge import hbram_pkg::*;
(
	input  logic                 ram_clk,
	input  logic                 ram_rstn,
	input  logic                 io_arw_valid_i,
	output logic                 io_arw_ready_o,
	input  logic [AXI_AW-1:0]    io_arw_addr_i,
	input  logic [ID_W-1:0]      io_arw_id_i,
	input  logic [LEN_W-1:0]     io_arw_len_i,
	input  logic [2:0]           io_arw_size_i,
	input  logic [1:0]           io_arw_burst_i,
	input  logic                 io_arw_write_i,
	input  logic                 io_w_valid_i,
	output logic                 io_w_ready_o,
	input  logic [AXI_DBW-1:0]   io_w_data_i,
	input  logic [AXI_STRBW-1:0] io_w_strb_i,
	input  logic                 io_w_last_i,
	input  logic [ID_W-1:0]      io_w_id_i,
	output logic                 io_b_valid_o,
	input  logic                 io_b_ready_i,
	output logic [ID_W-1:0]      io_b_id_o,
	output logic                 io_r_valid_o,
	input  logic                 io_r_ready_i,
	output logic [AXI_DBW-1:0]   io_r_data_o,
	output logic [ID_W-1:0]      io_r_id_o,
	output logic [1:0]           io_r_resp_o,
	output logic                 io_r_last_o,
	output logic                 h_req_o,
	output logic                 h_last_o,
	output logic [RAM_ABW-1:0]   h_addr_o,
	output logic                 h_btype_o,
	output logic                 h_rwen_o,
	input  logic                 h_mrdy_i,
	output logic [RAM_MW-1:0]    h_wdm_o,
	output logic [RAM_WW-1:0]    h_wdata_o,
	input  logic                 h_wrdy_i,
	input  logic [RAM_WW-1:0]    h_rdata_i,
	input  logic                 h_rdav_i
);

	logic             cmd_push;
	logic             cmd_pop;
	logic             cmd_empty;
	logic             cmd_full;
	logic [CMD_W-1:0] cmd_dout;
	logic             w_last_hs;
	logic             h_last_w;
	logic             h_last_r;

	hbram_burst_if burst ();

	assign io_arw_ready_o = !cmd_full && h_mrdy_i;
	assign cmd_push       = io_arw_valid_i && io_arw_ready_o;
	assign w_last_hs      = io_w_valid_i && io_w_ready_o && io_w_last_i;
	assign h_last_o       = h_last_w || h_last_r;
	assign io_r_resp_o    = 2'b00;

	hbram_sync_fifo #(
		.WIDTH (CMD_W),
		.DEPTH (CMD_DEPTH)
	) cmd_fifo_i (
		.ram_clk  (ram_clk),
		.ram_rstn (ram_rstn),
		.push_i   (cmd_push),
		.din_i    ({io_arw_id_i, io_arw_len_i, io_arw_size_i, io_arw_burst_i,
			io_arw_write_i, io_arw_addr_i}),
		.pop_i    (cmd_pop),
		.dout_o   (cmd_dout),
		.empty_o  (cmd_empty),
		.full_o   (cmd_full),
		.count_o  ()
	);

	hbram_burst_fsm burst_fsm_i (
		.ram_clk      (ram_clk),
		.ram_rstn     (ram_rstn),
		.cmd_empty_i  (cmd_empty),
		.cmd_pop_o    (cmd_pop),
		.cmd_i        (cmd_dout),
		.burst        (burst.seq),
		.h_req_o      (h_req_o),
		.h_addr_o     (h_addr_o),
		.h_rwen_o     (h_rwen_o),
		.h_btype_o    (h_btype_o),
		.w_id_i       (io_w_id_i),
		.w_last_hs_i  (w_last_hs),
		.io_b_valid_o (io_b_valid_o),
		.io_b_ready_i (io_b_ready_i),
		.io_b_id_o    (io_b_id_o),
		.r_id_o       (io_r_id_o)
	);

	hbram_wr_path wr_path_i (
		.ram_clk      (ram_clk),
		.ram_rstn     (ram_rstn),
		.burst        (burst.wr),
		.io_w_valid_i (io_w_valid_i),
		.io_w_ready_o (io_w_ready_o),
		.io_w_data_i  (io_w_data_i),
		.io_w_strb_i  (io_w_strb_i),
		.h_wrdy_i     (h_wrdy_i),
		.h_wdata_o    (h_wdata_o),
		.h_wdm_o      (h_wdm_o),
		.h_last_w_o   (h_last_w)
	);

	hbram_rd_path rd_path_i (
		.ram_clk      (ram_clk),
		.ram_rstn     (ram_rstn),
		.burst        (burst.rd),
		.h_rdav_i     (h_rdav_i),
		.h_rdata_i    (h_rdata_i),
		.h_last_r_o   (h_last_r),
		.io_r_valid_o (io_r_valid_o),
		.io_r_ready_i (io_r_ready_i),
		.io_r_data_o  (io_r_data_o),
		.io_r_last_o  (io_r_last_o)
	);

endmodule

// ==== src/hbram_burst_fsm.sv ====
// burst sequencer: command decode, RAM request fields and the write-response channel
`timescale 1ns/1ns

module hbram_burst_fsm import hbram_pkg::*;
(
	input  logic               ram_clk,
	input  logic               ram_rstn,
	input  logic               cmd_empty_i,
	output logic               cmd_pop_o,
	input  logic [CMD_W-1:0]   cmd_i,
	hbram_burst_if.seq         burst,
	output logic               h_req_o,
	output logic [RAM_ABW-1:0] h_addr_o,
	output logic               h_rwen_o,
	output logic               h_btype_o,
	input  logic [ID_W-1:0]    w_id_i,
	input  logic               w_last_hs_i,
	output logic               io_b_valid_o,
	input  logic               io_b_ready_i,
	output logic [ID_W-1:0]    io_b_id_o,
	output logic [ID_W-1:0]    r_id_o
);

	burst_state_t      state_q;
	burst_state_t      state_d;
	logic [CMD_W-1:0]  cmd_q;
	logic [AXI_AW-1:0] cmd_addr;
	logic              cmd_write;
	logic [1:0]        cmd_burst;
	logic [2:0]        cmd_size;
	logic [LEN_W-1:0]  cmd_len;
	logic [ID_W-1:0]   cmd_id;
	logic [AXI_AW-1:0] aligned_addr;

	assign {cmd_id, cmd_len, cmd_size, cmd_burst, cmd_write, cmd_addr} = cmd_q;
	assign aligned_addr = cmd_addr & ~size_align_mask(cmd_size);

	////////////////////////////////////////////////////////////////////////////
	// state sequence
	always_ff @(posedge ram_clk or negedge ram_rstn)
	begin
		if (!ram_rstn)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:     if (!cmd_empty_i) state_d = ST_POP;
			ST_POP:      state_d = ST_DECODE;
			ST_DECODE:   state_d = cmd_write ? ST_WR_FILL : ST_RD_XFER;
			ST_WR_FILL:  if (burst.wr_buffered) state_d = ST_WR_XFER;
			ST_WR_XFER:  if (burst.wr_done) state_d = ST_WR_RSP;
			ST_WR_RSP:   if (io_b_ready_i) state_d = ST_IDLE;
			ST_RD_XFER:  if (burst.rd_final) state_d = ST_RD_DRAIN;
			ST_RD_DRAIN: if (burst.rd_done) state_d = ST_IDLE;
			default:     state_d = ST_IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// command capture and decode
	always_ff @(posedge ram_clk)
	begin
		if (state_q == ST_POP)
			cmd_q <= cmd_i;
	end

	always_ff @(posedge ram_clk or negedge ram_rstn)
	begin
		if (!ram_rstn)
		begin
			h_addr_o    <= '0;
			h_rwen_o    <= 1'b0;
			h_btype_o   <= 1'b1;
			burst.beats <= '0;
			burst.size  <= '0;
			r_id_o      <= '0;
		end
		else if (state_q == ST_DECODE)
		begin
			h_addr_o    <= aligned_addr[RAM_ABW:1];
			h_rwen_o    <= !cmd_write;
			// only WRAP gives a wrapped RAM burst
			h_btype_o   <= (cmd_burst != 2'b10);
			burst.beats <= BEAT_CNT_W'(cmd_len) + 1'b1;
			burst.size  <= cmd_size;
			r_id_o      <= cmd_id;
		end
	end

	// B id follows the W channel, not the command
	always_ff @(posedge ram_clk)
	begin
		if (w_last_hs_i)
			io_b_id_o <= w_id_i;
	end

	assign cmd_pop_o     = (state_q == ST_POP);
	assign burst.wr_fill = (state_q == ST_WR_FILL);
	assign burst.wr_xfer = (state_q == ST_WR_XFER);
	assign burst.rd_xfer = (state_q == ST_RD_XFER);
	assign h_req_o       = burst.wr_xfer || burst.rd_xfer;
	assign io_b_valid_o  = (state_q == ST_WR_RSP);

	assert property (@(posedge ram_clk) disable iff (!ram_rstn)
		h_req_o |-> (h_rwen_o ? state_q == ST_RD_XFER : state_q == ST_WR_XFER));

endmodule

// ==== src/hbram_burst_if.sv ====
// control interface between the burst sequencer and the write and read data paths
`timescale 1ns/1ns

interface hbram_burst_if import hbram_pkg::*; ();

	logic                  wr_fill;
	logic                  wr_xfer;
	logic                  rd_xfer;
	logic [BEAT_CNT_W-1:0] beats;
	logic [2:0]            size;
	logic                  wr_buffered;
	logic                  wr_done;
	// final RAM word of a read captured
	logic                  rd_final;
	logic                  rd_done;

	modport seq (
		output wr_fill, wr_xfer, rd_xfer, beats, size,
		input  wr_buffered, wr_done, rd_final, rd_done
	);

	modport wr (
		input  wr_fill, wr_xfer, beats, size,
		output wr_buffered, wr_done
	);

	modport rd (
		input  rd_xfer, beats, size,
		output rd_final, rd_done
	);

endinterface

// ==== src/hbram_pkg.sv ====
// bridge widths, depths, burst FSM state encoding and transfer-size mask helpers
package hbram_pkg;

	localparam int AXI_DBW    = 32;
	localparam int AXI_STRBW  = AXI_DBW/8;
	localparam int AXI_AW     = 32;
	localparam int ID_W       = 8;
	localparam int LEN_W      = 8;
	localparam int RAM_DBW    = 8;
	localparam int RAM_WW     = RAM_DBW*2;
	localparam int RAM_MW     = RAM_DBW/4;
	localparam int RAM_ABW    = 25;
	localparam int C_RATIO    = AXI_DBW/RAM_WW;
	localparam int BEAT_CNT_W = 5;
	localparam int WORD_CNT_W = BEAT_CNT_W+1;
	localparam int MAX_BEATS  = 16;
	localparam int CMD_DEPTH  = 4;
	localparam int DATA_DEPTH = 32;
	localparam int DATA_CNT_W = $clog2(DATA_DEPTH+1);
	// {id, len, size, burst, write, addr}
	localparam int CMD_W      = ID_W+LEN_W+3+2+1+AXI_AW;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_POP,
		ST_DECODE,
		ST_WR_FILL,
		ST_WR_XFER,
		ST_WR_RSP,
		ST_RD_XFER,
		ST_RD_DRAIN
	} burst_state_t;

	function automatic logic [AXI_DBW-1:0] size_data_mask(input logic [2:0] size);
		case (size)
			3'd0:    return {{(AXI_DBW-8){1'b0}}, {8{1'b1}}};
			3'd1:    return {{(AXI_DBW-16){1'b0}}, {16{1'b1}}};
			default: return {AXI_DBW{1'b1}};
		endcase
	endfunction

	function automatic logic [AXI_STRBW-1:0] size_strb_mask(input logic [2:0] size);
		case (size)
			3'd0:    return {{(AXI_STRBW-1){1'b0}}, 1'b1};
			3'd1:    return {{(AXI_STRBW-2){1'b0}}, 2'b11};
			default: return {AXI_STRBW{1'b1}};
		endcase
	endfunction

	// low byte-address bits below the transfer size
	function automatic logic [AXI_AW-1:0] size_align_mask(input logic [2:0] size);
		case (size)
			3'd0:    return '0;
			3'd1:    return AXI_AW'(1);
			default: return AXI_AW'(3);
		endcase
	endfunction

endpackage

// ==== src/hbram_rd_path.sv ====
// read path: RAM word join into AXI beats, read buffering and the R channel
`timescale 1ns/1ns

module hbram_rd_path import hbram_pkg::*;
(
	input  logic               ram_clk,
	input  logic               ram_rstn,
	hbram_burst_if.rd          burst,
	input  logic               h_rdav_i,
	input  logic [RAM_WW-1:0]  h_rdata_i,
	output logic               h_last_r_o,
	output logic               io_r_valid_o,
	input  logic               io_r_ready_i,
	output logic [AXI_DBW-1:0] io_r_data_o,
	output logic               io_r_last_o
);

	logic                  rd_go;
	logic                  word_final;
	logic                  r_push;
	logic                  r_pop;
	logic                  r_empty;
	logic [RAM_WW-1:0]     lo_q;
	logic [AXI_DBW:0]      r_dout;
	logic [WORD_CNT_W-1:0] word_cnt;

	assign rd_go      = burst.rd_xfer && h_rdav_i;
	assign word_final = (word_cnt == WORD_CNT_W'(burst.beats*C_RATIO - 1));
	// odd word completes a beat
	assign r_push     = rd_go && word_cnt[0];

	always_ff @(posedge ram_clk or negedge ram_rstn)
	begin
		if (!ram_rstn)
		begin
			word_cnt   <= '0;
			h_last_r_o <= 1'b0;
		end
		else
		begin
			if (!burst.rd_xfer)
				word_cnt <= '0;
			else if (rd_go)
				word_cnt <= word_cnt + 1'b1;
			h_last_r_o <= rd_go && word_final;
		end
	end

	always_ff @(posedge ram_clk)
	begin
		if (rd_go && !word_cnt[0])
			lo_q <= h_rdata_i;
	end

	assign burst.rd_final = rd_go && word_final;

	////////////////////////////////////////////////////////////////////////////
	// beat buffer, {last, data}
	hbram_sync_fifo #(
		.WIDTH (AXI_DBW+1),
		.DEPTH (DATA_DEPTH)
	) r_fifo_i (
		.ram_clk  (ram_clk),
		.ram_rstn (ram_rstn),
		.push_i   (r_push),
		.din_i    ({word_final, h_rdata_i, lo_q}),
		.pop_i    (r_pop),
		.dout_o   (r_dout),
		.empty_o  (r_empty),
		.full_o   (),
		.count_o  ()
	);

	assign io_r_valid_o  = !r_empty;
	assign io_r_data_o   = r_dout[AXI_DBW-1:0] & size_data_mask(burst.size);
	assign io_r_last_o   = io_r_valid_o && r_dout[AXI_DBW];
	assign r_pop         = io_r_valid_o && io_r_ready_i;
	assign burst.rd_done = r_pop && r_dout[AXI_DBW];

endmodule

// ==== src/hbram_sync_fifo.sv ====
// synchronous first-word-fall-through FIFO with occupancy count
`timescale 1ns/1ns

module hbram_sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic                       ram_clk,
	input  logic                       ram_rstn,
	input  logic                       push_i,
	input  logic [WIDTH-1:0]           din_i,
	input  logic                       pop_i,
	output logic [WIDTH-1:0]           dout_o,
	output logic                       empty_o,
	output logic                       full_o,
	output logic [$clog2(DEPTH+1)-1:0] count_o
);

	logic [WIDTH-1:0]         mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;

	always_ff @(posedge ram_clk)
	begin
		if (push_i)
			mem[wr_ptr] <= din_i;
	end

	// pointers wrap on their own, DEPTH is a power of two
	always_ff @(posedge ram_clk or negedge ram_rstn)
	begin
		if (!ram_rstn)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_i && !pop_i)
				count_o <= count_o + 1'b1;
			else if (pop_i && !push_i)
				count_o <= count_o - 1'b1;
		end
	end

	assign dout_o  = mem[rd_ptr];
	assign empty_o = (count_o == 0);
	assign full_o  = (count_o == DEPTH);

	assert property (@(posedge ram_clk) disable iff (!ram_rstn) push_i |-> !full_o);
	assert property (@(posedge ram_clk) disable iff (!ram_rstn) pop_i |-> !empty_o);

endmodule

// ==== src/hbram_wr_path.sv ====
// write path: W beat masking and buffering, split into RAM words, write last flag
`timescale 1ns/1ns

module hbram_wr_path import hbram_pkg::*;
(
	input  logic                 ram_clk,
	input  logic                 ram_rstn,
	hbram_burst_if.wr            burst,
	input  logic                 io_w_valid_i,
	output logic                 io_w_ready_o,
	input  logic [AXI_DBW-1:0]   io_w_data_i,
	input  logic [AXI_STRBW-1:0] io_w_strb_i,
	input  logic                 h_wrdy_i,
	output logic [RAM_WW-1:0]    h_wdata_o,
	output logic [RAM_MW-1:0]    h_wdm_o,
	output logic                 h_last_w_o
);

	logic                         w_push;
	logic                         w_pop;
	logic [DATA_CNT_W-1:0]        w_count;
	logic [AXI_STRBW+AXI_DBW-1:0] w_dout;
	logic [AXI_DBW-1:0]           beat_data;
	logic [AXI_STRBW-1:0]         beat_strb;
	logic [WORD_CNT_W-1:0]        word_cnt;
	logic                         word_go;
	logic                         word_final;

	assign io_w_ready_o      = burst.wr_fill && (w_count < DATA_CNT_W'(burst.beats));
	assign w_push            = io_w_valid_i && io_w_ready_o;
	assign burst.wr_buffered = (w_count == DATA_CNT_W'(burst.beats));

	hbram_sync_fifo #(
		.WIDTH (AXI_STRBW+AXI_DBW),
		.DEPTH (DATA_DEPTH)
	) w_fifo_i (
		.ram_clk  (ram_clk),
		.ram_rstn (ram_rstn),
		.push_i   (w_push),
		.din_i    ({io_w_strb_i & size_strb_mask(burst.size),
			io_w_data_i & size_data_mask(burst.size)}),
		.pop_i    (w_pop),
		.dout_o   (w_dout),
		.empty_o  (),
		.full_o   (),
		.count_o  (w_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// word split, low half first
	assign {beat_strb, beat_data} = w_dout;
	assign word_go    = burst.wr_xfer && h_wrdy_i;
	assign word_final = (word_cnt == WORD_CNT_W'(burst.beats*C_RATIO - 1));
	assign w_pop      = word_go && word_cnt[0];

	always_ff @(posedge ram_clk or negedge ram_rstn)
	begin
		if (!ram_rstn)
			word_cnt <= '0;
		else if (!burst.wr_xfer)
			word_cnt <= '0;
		else if (word_go)
			word_cnt <= word_cnt + 1'b1;
	end

	assign h_wdata_o = beat_data[word_cnt[0]*RAM_WW +: RAM_WW];
	// mask is active high on the RAM side
	assign h_wdm_o   = word_go ? ~beat_strb[word_cnt[0]*RAM_MW +: RAM_MW] : {RAM_MW{1'b1}};

	assign h_last_w_o    = word_go && word_final;
	assign burst.wr_done = word_go && word_final;

endmodule

// ==== test/tb_hbram_axi_bridge.sv ====
// testbench for the AXI to HyperRAM bridge: test table, RAM model, checks and watchdog
`timescale 1ns/1ns

module tb_hbram_axi_bridge import hbram_pkg::*; ();

	logic                 ram_clk;
	logic                 ram_rstn;
	logic                 io_arw_valid_i;
	logic                 io_arw_ready_o;
	logic [AXI_AW-1:0]    io_arw_addr_i;
	logic [ID_W-1:0]      io_arw_id_i;
	logic [LEN_W-1:0]     io_arw_len_i;
	logic [2:0]           io_arw_size_i;
	logic [1:0]           io_arw_burst_i;
	logic                 io_arw_write_i;
	logic                 io_w_valid_i;
	logic                 io_w_ready_o;
	logic [AXI_DBW-1:0]   io_w_data_i;
	logic [AXI_STRBW-1:0] io_w_strb_i;
	logic                 io_w_last_i;
	logic [ID_W-1:0]      io_w_id_i;
	logic                 io_b_valid_o;
	logic                 io_b_ready_i;
	logic [ID_W-1:0]      io_b_id_o;
	logic                 io_r_valid_o;
	logic                 io_r_ready_i;
	logic [AXI_DBW-1:0]   io_r_data_o;
	logic [ID_W-1:0]      io_r_id_o;
	logic [1:0]           io_r_resp_o;
	logic                 io_r_last_o;
	logic                 h_req_o;
	logic                 h_last_o;
	logic [RAM_ABW-1:0]   h_addr_o;
	logic                 h_btype_o;
	logic                 h_rwen_o;
	logic                 h_mrdy_i;
	logic [RAM_MW-1:0]    h_wdm_o;
	logic [RAM_WW-1:0]    h_wdata_o;
	logic                 h_wrdy_i;
	logic [RAM_WW-1:0]    h_rdata_i;
	logic                 h_rdav_i;

	// test table columns
	string       t_name[$];
	bit          t_wr[$];
	logic [31:0] t_addr[$];
	int          t_len[$];
	logic [2:0]  t_size[$];
	logic [1:0]  t_burst[$];
	logic [7:0]  t_id[$];
	logic [7:0]  t_seed[$];
	bit          t_bp[$];

	logic [15:0] ram_mem [int];
	logic [15:0] ref_mem [int];
	logic [31:0] lfsr = 32'h9c307f44;
	string       cur_name;
	int          cur_words;
	int          cur_base;
	bit          cur_wrap;
	bit          bp_mode;
	int          word_idx;
	int          ram_a;
	int          rd_a;
	int          last_cnt;
	int          last_word;
	bit          req_seen;
	logic [24:0] req_addr;
	logic        req_btype;
	logic        req_rwen;
	int          test_err;
	int          n_pass;
	int          n_fail;
	int          n_err;
	int          t;

	hbram_axi_bridge hbram_axi_bridge_i (.*);

	initial
	begin
		ram_clk = 1'b0;
		forever #4 ram_clk = ~ram_clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] fill_word(input int a);
		return 16'(a) ^ 16'(a >> 9) ^ 16'h6b2d;
	endfunction

	function automatic int word_addr(input int start, input int idx, input int nwords,
		input bit wrap);
		if (wrap)
			return (start & ~(nwords - 1)) | ((start + idx) & (nwords - 1));
		return start + idx;
	endfunction

	function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
		input logic [15:0] new_w, input logic [1:0] en);
		return {en[1] ? new_w[15:8] : old_w[15:8], en[0] ? new_w[7:0] : old_w[7:0]};
	endfunction

	function automatic logic [31:0] size_mask(input logic [2:0] size);
		return (size == 0) ? 32'h0000_00ff : (size == 1) ? 32'h0000_ffff : 32'hffff_ffff;
	endfunction

	function automatic int word_base(input logic [31:0] addr, input logic [2:0] size);
		logic [31:0] aligned;
		aligned = (size == 0) ? addr : (size == 1) ? addr & ~32'h1 : addr & ~32'h3;
		return int'(aligned >> 1);
	endfunction

	function automatic logic [31:0] beat_data(input logic [7:0] seed, input int i);
		return {seed, 8'(i), seed ^ 8'h5a, 8'(i * 37)};
	endfunction

	function automatic logic [15:0] ref_get(input int a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	task add_test(input string name, input bit wr, input logic [31:0] addr, input int len,
		input logic [2:0] size, input logic [1:0] burst, input logic [7:0] id,
		input logic [7:0] seed, input bit bp);
		t_name.push_back(name);
		t_wr.push_back(wr);
		t_addr.push_back(addr);
		t_len.push_back(len);
		t_size.push_back(size);
		t_burst.push_back(burst);
		t_id.push_back(id);
		t_seed.push_back(seed);
		t_bp.push_back(bp);
	endtask

	task check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("ERROR %s %s: expected %h, actual %h", cur_name, what, exp, act);
			test_err++;
			n_err++;
		end
	endtask

	task finish_test();
		if (test_err == 0)
		begin
			n_pass++;
			$display("test %s: ok", cur_name);
		end
		else
		begin
			n_fail++;
			$display("test %s: %0d mismatches", cur_name, test_err);
		end
	endtask

	task send_cmd(input int k);
		@(posedge ram_clk);
		#1;
		io_arw_valid_i = 1'b1;
		io_arw_addr_i  = t_addr[k];
		io_arw_id_i    = t_id[k];
		io_arw_len_i   = LEN_W'(t_len[k]);
		io_arw_size_i  = t_size[k];
		io_arw_burst_i = t_burst[k];
		io_arw_write_i = t_wr[k];
		@(negedge ram_clk);
		while (!io_arw_ready_o)
			@(negedge ram_clk);
		@(posedge ram_clk);
		#1;
		io_arw_valid_i = 1'b0;
	endtask

	task send_w(input int k);
		logic [31:0] d;
		logic [3:0]  s;
		int          a0;
		int          a1;
		for (int i = 0; i <= t_len[k]; i++)
		begin
			io_w_valid_i = 1'b1;
			io_w_data_i  = beat_data(t_seed[k], i);
			io_w_strb_i  = (i == 1) ? 4'b1101 : 4'hf;
			io_w_last_i  = (i == t_len[k]);
			io_w_id_i    = t_id[k] ^ 8'h80;
			// expected RAM contents with the low half first
			d  = io_w_data_i & size_mask(t_size[k]);
			s  = io_w_strb_i;
			s  = (t_size[k] == 0) ? (s & 4'h1) : (t_size[k] == 1) ? (s & 4'h3) : s;
			a0 = word_addr(cur_base, 2 * i, cur_words, cur_wrap);
			a1 = word_addr(cur_base, 2 * i + 1, cur_words, cur_wrap);
			ref_mem[a0] = merge_bytes(ref_get(a0), d[15:0], s[1:0]);
			ref_mem[a1] = merge_bytes(ref_get(a1), d[31:16], s[3:2]);
			@(negedge ram_clk);
			while (!io_w_ready_o)
				@(negedge ram_clk);
			@(posedge ram_clk);
			#1;
		end
		io_w_valid_i = 1'b0;
		io_w_last_i  = 1'b0;
	endtask

	task wait_b(input int k);
		@(negedge ram_clk);
		while (!io_b_valid_o)
			@(negedge ram_clk);
		check("b_id", t_id[k] ^ 8'h80, io_b_id_o);
		@(posedge ram_clk);
		#1 io_b_ready_i = 1'b1;
		@(posedge ram_clk);
		#1 io_b_ready_i = 1'b0;
	endtask

	task read_beats(input int k);
		int          beat;
		logic [31:0] exp;
		beat = 0;
		while (beat <= t_len[k])
		begin
			@(negedge ram_clk);
			if (io_r_valid_o && io_r_ready_i)
			begin
				exp = {ref_get(word_addr(cur_base, 2 * beat + 1, cur_words, cur_wrap)),
					ref_get(word_addr(cur_base, 2 * beat, cur_words, cur_wrap))};
				check("r_data", exp & size_mask(t_size[k]), io_r_data_o);
				check("r_last", beat == t_len[k], io_r_last_o);
				check("r_id", t_id[k], io_r_id_o);
				check("r_resp", 0, io_r_resp_o);
				beat++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// HyperRAM model
	always @(negedge ram_clk)
	begin
		if (h_last_o)
		begin
			last_cnt++;
			if (h_req_o && !h_rwen_o)
				last_word = word_idx;
		end
		if (!h_req_o)
			word_idx = 0;
		else
		begin
			if (!req_seen)
			begin
				req_seen  = 1'b1;
				req_addr  = h_addr_o;
				req_btype = h_btype_o;
				req_rwen  = h_rwen_o;
			end
			ram_a = word_addr(h_addr_o, word_idx, cur_words, !h_btype_o);
			if (!h_rwen_o && h_wrdy_i)
			begin
				ram_mem[ram_a] = merge_bytes(ram_mem.exists(ram_a) ? ram_mem[ram_a] :
					fill_word(ram_a), h_wdata_o, ~h_wdm_o);
				word_idx++;
			end
			else if (h_rwen_o && h_rdav_i)
				word_idx++;
		end
	end

	// one LFSR step per random bit
	always @(posedge ram_clk)
	begin
		#1;
		lfsr = lfsr_next(lfsr);
		h_wrdy_i = lfsr[0];
		lfsr = lfsr_next(lfsr);
		h_rdav_i = lfsr[0];
		lfsr = lfsr_next(lfsr);
		io_r_ready_i = bp_mode ? lfsr[0] : 1'b1;
		rd_a = word_addr(h_addr_o, word_idx, cur_words, !h_btype_o);
		h_rdata_i = ram_mem.exists(rd_a) ? ram_mem[rd_a] : fill_word(rd_a);
	end

	initial
	begin
		#1;
		repeat (t_name.size() * MAX_BEATS * 64) @(posedge ram_clk);
		$display("timeout: the tests did not finish within the cycle limit");
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		ram_rstn       = 1'b0;
		io_arw_valid_i = 1'b0;
		io_arw_addr_i  = '0;
		io_arw_id_i    = '0;
		io_arw_len_i   = '0;
		io_arw_size_i  = '0;
		io_arw_burst_i = '0;
		io_arw_write_i = 1'b0;
		io_w_valid_i   = 1'b0;
		io_w_data_i    = '0;
		io_w_strb_i    = '0;
		io_w_last_i    = 1'b0;
		io_w_id_i      = '0;
		io_b_ready_i   = 1'b0;
		io_r_ready_i   = 1'b0;
		h_mrdy_i       = 1'b1;
		h_wrdy_i       = 1'b0;
		h_rdav_i       = 1'b0;
		h_rdata_i      = '0;
		cur_words      = 2;
		// name, write, addr, len, size, burst, id, seed, r_ready toggling
		add_test("wr_incr_full", 1, 32'h0000_0100, 7, 3'd2, 2'b01, 8'h11, 8'h01, 0);
		add_test("rd_incr_full", 0, 32'h0000_0100, 7, 3'd2, 2'b01, 8'h21, 8'h00, 0);
		add_test("wr_wrap", 1, 32'h0000_0208, 3, 3'd2, 2'b10, 8'h32, 8'h47, 0);
		add_test("rd_wrap", 0, 32'h0000_0208, 3, 3'd2, 2'b10, 8'h33, 8'h00, 0);
		add_test("wr_narrow", 1, 32'h0000_0301, 3, 3'd1, 2'b01, 8'h43, 8'h9e, 0);
		add_test("rd_narrow", 0, 32'h0000_0301, 3, 3'd1, 2'b01, 8'h44, 8'h00, 0);
		add_test("rd_narrow_full", 0, 32'h0000_0300, 3, 3'd2, 2'b01, 8'h45, 8'h00, 0);
		add_test("wr_long", 1, 32'h0000_0400, 15, 3'd2, 2'b01, 8'h54, 8'hc8, 0);
		add_test("rd_long_bp", 0, 32'h0000_0400, 15, 3'd2, 2'b01, 8'h65, 8'h00, 1);
		add_test("rd_incr_bp", 0, 32'h0000_0100, 7, 3'd2, 2'b01, 8'h76, 8'h00, 1);
		repeat (5) @(posedge ram_clk);
		#1 ram_rstn = 1'b1;
		@(negedge ram_clk);
		cur_name = "reset";
		test_err = 0;
		check("h_req", 0, h_req_o);
		check("b_valid", 0, io_b_valid_o);
		check("r_valid", 0, io_r_valid_o);
		check("w_ready", 0, io_w_ready_o);
		check("arw_ready", 1, io_arw_ready_o);
		finish_test();
		for (t = 0; t < t_name.size(); t++)
		begin
			cur_name  = t_name[t];
			test_err  = 0;
			cur_words = 2 * (t_len[t] + 1);
			cur_base  = word_base(t_addr[t], t_size[t]);
			cur_wrap  = (t_burst[t] == 2'b10);
			bp_mode   = t_bp[t];
			req_seen  = 1'b0;
			last_cnt  = 0;
			send_cmd(t);
			if (t_wr[t])
			begin
				send_w(t);
				wait_b(t);
			end
			else
				read_beats(t);
			repeat (3) @(posedge ram_clk);
			#1;
			check("h_req seen", 1, req_seen);
			check("h_addr", cur_base, req_addr);
			check("h_btype", !cur_wrap, req_btype);
			check("h_rwen", !t_wr[t], req_rwen);
			check("h_last count", 1, last_cnt);
			if (t_wr[t])
				check("h_last word", cur_words - 1, last_word);
			else
				check("r_valid after burst", 0, io_r_valid_o);
			finish_test();
		end
		$display("%0d tests: %0d passed, %0d failed, %0d errors", n_pass + n_fail, n_pass,
			n_fail, n_err);
		if (n_fail == 0 && n_err == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
src/hbram_pkg.sv
src/hbram_burst_if.sv
src/hbram_sync_fifo.sv
src/hbram_burst_fsm.sv
src/hbram_wr_path.sv
src/hbram_rd_path.sv
src/hbram_axi_bridge.sv
test/tb_hbram_axi_bridge.sv
